// File: rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int NUM_WAYS = 4;

    typedef logic [14:0]  paddr_t;
    typedef logic [7:0]   tag_t;
    typedef logic [1:0]   index_t;
    typedef logic [127:0] line_t;
    typedef logic [3:0]   way_oh_t;
    typedef logic [2:0]   plru_t;

    typedef struct packed {
        paddr_t addr;
        logic   rd;
        logic   wr;
        line_t  data;
        line_t  mask;
    } cache_req_t;

    // Driven to every way in the same cycle
    typedef struct packed {
        index_t index;
        tag_t   tag;
        line_t  data;
        line_t  mask;
        logic   fill;
    } way_ctl_t;

    typedef struct packed {
        logic  hit;
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } way_res_t;

    // Tag in 14:7 and index in 6:5 above a 5-bit offset
    function automatic tag_t addr_tag(paddr_t addr);
        return addr[14:7];
    endfunction

    function automatic index_t addr_index(paddr_t addr);
        return addr[6:5];
    endfunction

    function automatic paddr_t line_addr(tag_t tag, index_t index);
        return {tag, index, 5'b0};
    endfunction

endpackage

`default_nettype wire

// File: rtl/cache_stage1.sv
`default_nettype none

module cache_stage1 import cache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       valid,
    input  cache_req_t req,
    input  logic       fill_valid,
    input  paddr_t     fill_addr,
    input  line_t      fill_line,
    input  logic       mshr_full,
    output logic       valid_out,
    output logic       hit,
    output logic       miss,
    output line_t      cache_line,
    output paddr_t     ext_addr,
    output logic       stall,
    output logic       ex_wb,
    output paddr_t     wb_addr,
    output line_t      wb_line
);

    way_ctl_t   ctl;
    way_res_t   res [NUM_WAYS];
    way_oh_t    we;
    logic       hold;
    logic       req_valid;
    cache_req_t req_q;

    req_decode decode_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (valid),
        .req        (req),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_line  (fill_line),
        .hold       (hold),
        .ctl        (ctl),
        .req_valid  (req_valid),
        .req_q      (req_q)
    );

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        cache_way way_i (
            .clk   (clk),
            .rst_n (rst_n),
            .ctl   (ctl),
            .we    (we[i]),
            .res   (res[i])
        );
    end

    way_resolve resolve_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_q      (req_q),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .mshr_full  (mshr_full),
        .res        (res),
        .we         (we),
        .hold       (hold),
        .valid_out  (valid_out),
        .hit        (hit),
        .miss       (miss),
        .cache_line (cache_line),
        .ext_addr   (ext_addr),
        .stall      (stall),
        .ex_wb      (ex_wb),
        .wb_addr    (wb_addr),
        .wb_line    (wb_line)
    );

endmodule

`default_nettype wire

// File: rtl/cache_way.sv
`default_nettype none

module cache_way import cache_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  way_ctl_t ctl,
    input  logic     we,
    output way_res_t res
);

    localparam int NUM_SETS = 2 ** $bits(index_t);

    tag_t                tags  [NUM_SETS];
    line_t               lines [NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits;
    logic [NUM_SETS-1:0] dirty_bits;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bits <= '0;
        end else if (we && ctl.fill) begin
            valid_bits[ctl.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            if (ctl.fill) begin
                tags[ctl.index]       <= ctl.tag;
                lines[ctl.index]      <= ctl.data;
                dirty_bits[ctl.index] <= 1'b0;
            end else begin
                // Write hit changes only the masked bits
                lines[ctl.index]      <= (lines[ctl.index] & ~ctl.mask) |
                                         (ctl.data & ctl.mask);
                dirty_bits[ctl.index] <= 1'b1;
            end
        end
    end

    always_comb begin
        res.valid = valid_bits[ctl.index];
        res.dirty = dirty_bits[ctl.index];
        res.tag   = tags[ctl.index];
        res.line  = lines[ctl.index];
        res.hit   = res.valid && (res.tag == ctl.tag);
    end

endmodule

`default_nettype wire

// File: rtl/req_decode.sv
`default_nettype none

module req_decode import cache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       valid,
    input  cache_req_t req,
    input  logic       fill_valid,
    input  paddr_t     fill_addr,
    input  line_t      fill_line,
    input  logic       hold,
    output way_ctl_t   ctl,
    output logic       req_valid,
    output cache_req_t req_q
);

    logic accept;

    assign accept = valid && !hold;

    // Request stays in place while the resolver holds it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else if (!hold) begin
            req_valid <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // Fill owns the way port in its cycle
    always_comb begin
        if (fill_valid) begin
            ctl.index = addr_index(fill_addr);
            ctl.tag   = addr_tag(fill_addr);
            ctl.data  = fill_line;
            ctl.mask  = '1;
            ctl.fill  = 1'b1;
        end else begin
            ctl.index = addr_index(req_q.addr);
            ctl.tag   = addr_tag(req_q.addr);
            ctl.data  = req_q.data;
            ctl.mask  = req_q.mask;
            ctl.fill  = 1'b0;
        end
    end

    a_no_req_with_fill: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(valid && fill_valid)
    );

    // An accepted request is either a read or a write
    a_single_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        accept |-> (req.rd != req.wr)
    );

endmodule

`default_nettype wire

// File: rtl/way_resolve.sv
`default_nettype none

module way_resolve import cache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  cache_req_t req_q,
    input  logic       fill_valid,
    input  paddr_t     fill_addr,
    input  logic       mshr_full,
    input  way_res_t   res [NUM_WAYS],
    output way_oh_t    we,
    output logic       hold,
    output logic       valid_out,
    output logic       hit,
    output logic       miss,
    output line_t      cache_line,
    output paddr_t     ext_addr,
    output logic       stall,
    output logic       ex_wb,
    output paddr_t     wb_addr,
    output line_t      wb_line
);

    localparam int NUM_SETS = 2 ** $bits(index_t);

    way_oh_t    hits;
    logic       any_hit;
    logic       req_active;
    logic       write_hit;
    logic       have_invalid;
    logic [1:0] hit_idx;
    logic [1:0] victim_idx;
    logic [1:0] use_idx;
    way_oh_t    victim_oh;
    index_t     acc_index;
    plru_t      plru [NUM_SETS];
    plru_t      plru_cur;
    plru_t      plru_next;
    logic       plru_upd;

    always_comb begin
        hit_idx = 2'd0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            hits[i] = res[i].hit;
            if (res[i].hit) begin
                hit_idx = i[1:0];
            end
        end
    end

    assign any_hit    = |hits;
    assign cache_line = any_hit ? res[hit_idx].line : '0;

    // A request that shares its cycle with a fill waits one cycle
    assign req_active = req_valid && !fill_valid;
    assign stall      = req_active && !any_hit && mshr_full;
    assign hold       = (req_valid && fill_valid) || stall;
    assign valid_out  = req_active && !stall;
    assign hit        = req_active && any_hit;
    assign miss       = req_active && !any_hit;
    assign ext_addr   = line_addr(addr_tag(req_q.addr), addr_index(req_q.addr));

    assign acc_index = fill_valid ? addr_index(fill_addr) : addr_index(req_q.addr);
    assign plru_cur  = plru[acc_index];

    // Lowest invalid way or else the tree walk
    always_comb begin
        have_invalid = 1'b0;
        victim_idx   = 2'd0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (!res[i].valid) begin
                have_invalid = 1'b1;
                victim_idx   = i[1:0];
            end
        end
        if (!have_invalid) begin
            if (plru_cur[0]) begin
                victim_idx = {1'b1, plru_cur[2]};
            end else begin
                victim_idx = {1'b0, plru_cur[1]};
            end
        end
    end

    assign victim_oh = way_oh_t'(1) << victim_idx;
    assign write_hit = valid_out && any_hit && req_q.wr;
    assign we        = fill_valid ? victim_oh : (write_hit ? hits : '0);

    assign ex_wb   = fill_valid && res[victim_idx].valid && res[victim_idx].dirty;
    assign wb_addr = line_addr(res[victim_idx].tag, addr_index(fill_addr));
    assign wb_line = res[victim_idx].line;

    assign use_idx  = fill_valid ? victim_idx : hit_idx;
    assign plru_upd = fill_valid || (valid_out && any_hit);

    // Point the tree away from the way just used
    always_comb begin
        plru_next = plru_cur;
        if (use_idx[1]) begin
            plru_next[0] = 1'b0;
            plru_next[2] = ~use_idx[0];
        end else begin
            plru_next[0] = 1'b1;
            plru_next[1] = ~use_idx[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru[s] <= '0;
            end
        end else if (plru_upd) begin
            plru[acc_index] <= plru_next;
        end
    end

    // Tags in one set never repeat across ways
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(hits)
    );

endmodule

`default_nettype wire

// File: sim/tb_cache_stage1.sv
`default_nettype none

module tb_cache_stage1 import cache_pkg::*; ();

    localparam int TIMEOUT = 20;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       valid;
    cache_req_t req;
    logic       fill_valid;
    paddr_t     fill_addr;
    line_t      fill_line;
    logic       mshr_full;
    logic       valid_out;
    logic       hit;
    logic       miss;
    line_t      cache_line;
    paddr_t     ext_addr;
    logic       stall;
    logic       ex_wb;
    paddr_t     wb_addr;
    line_t      wb_line;

    logic [31:0] lfsr   = 32'h6579;
    int          errors = 0;
    int          checks = 0;
    logic        abort  = 1'b0;

    // Reference model indexed by [set][way]
    tag_t  m_tag   [4][4];
    line_t m_line  [4][4];
    logic  m_valid [4][4];
    logic  m_dirty [4][4];
    plru_t m_plru  [4];

    cache_stage1 dut_i (.*);

    always #5 clk = ~clk;

    always @(posedge abort) begin
        $display("ERRORS FOUND");
        $finish;
    end

    // One LFSR step per bit taken
    function automatic logic [127:0] rand_bits(int n);
        logic [127:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[126:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check(string what, logic [127:0] got, logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic give_up(string what);
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        abort = 1'b1;
        wait (!abort);
    endtask

    task automatic report(string name);
        $display("%s finished, %0d errors so far", name, errors);
    endtask

    function automatic int model_way(paddr_t addr);
        int w;
        w = -1;
        for (int i = 0; i < 4; i++) begin
            if (m_valid[addr[6:5]][i] && m_tag[addr[6:5]][i] == addr[14:7]) begin
                w = i;
            end
        end
        return w;
    endfunction

    function automatic int model_victim(index_t s);
        for (int i = 0; i < 4; i++) begin
            if (!m_valid[s][i]) begin
                return i;
            end
        end
        if (m_plru[s][0]) begin
            return m_plru[s][2] ? 3 : 2;
        end
        return m_plru[s][1] ? 1 : 0;
    endfunction

    // Tree bits point away from the way just used
    task automatic model_touch(index_t s, int w);
        if (w >= 2) begin
            m_plru[s][0] = 1'b0;
            m_plru[s][2] = (w == 2);
        end else begin
            m_plru[s][0] = 1'b1;
            m_plru[s][1] = (w == 0);
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int s = 0; s < 4; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < 4; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
    endtask

    task automatic drive_req(logic wr, paddr_t addr, line_t data, line_t mask);
        valid    = 1'b1;
        req.addr = addr;
        req.rd   = !wr;
        req.wr   = wr;
        req.data = data;
        req.mask = mask;
        @(posedge clk);
        #1 valid = 1'b0;
    endtask

    task automatic do_req(logic wr, paddr_t addr, line_t data, line_t mask);
        int     lat;
        int     w;
        index_t s;
        lat = 0;
        w   = model_way(addr);
        s   = addr[6:5];
        drive_req(wr, addr, data, mask);
        do begin
            @(negedge clk);
            lat++;
        end while (!valid_out && lat < TIMEOUT);
        if (!valid_out) begin
            give_up("valid_out after a request");
        end
        check("latency", lat, 1);
        check("hit", hit, w >= 0);
        check("miss", miss, w < 0);
        check("ext_addr", ext_addr, {addr[14:5], 5'b0});
        check("ex_wb on request", ex_wb, 1'b0);
        if (w >= 0) begin
            check("cache_line", cache_line, m_line[s][w]);
            if (wr) begin
                // Each set mask bit takes the write data bit
                for (int b = 0; b < $bits(line_t); b++) begin
                    if (mask[b]) begin
                        m_line[s][w][b] = data[b];
                    end
                end
                m_dirty[s][w] = 1'b1;
            end
            model_touch(s, w);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic do_fill(paddr_t addr, line_t line);
        index_t s;
        int     v;
        s          = addr[6:5];
        v          = model_victim(s);
        fill_valid = 1'b1;
        fill_addr  = addr;
        fill_line  = line;
        @(negedge clk);
        check("ex_wb", ex_wb, m_valid[s][v] && m_dirty[s][v]);
        if (m_valid[s][v] && m_dirty[s][v]) begin
            check("wb_addr", wb_addr, {m_tag[s][v], s, 5'b0});
            check("wb_line", wb_line, m_line[s][v]);
        end
        m_tag[s][v]   = addr[14:7];
        m_line[s][v]  = line;
        m_valid[s][v] = 1'b1;
        m_dirty[s][v] = 1'b0;
        model_touch(s, v);
        @(posedge clk);
        #1 fill_valid = 1'b0;
    endtask

    task automatic test_reset_miss();
        apply_reset();
        repeat (4) begin
            do_req(1'b0, paddr_t'(rand_bits(15)), '0, '0);
        end
        report("reset miss");
    endtask

    task automatic test_fill_hit();
        paddr_t a;
        apply_reset();
        a = paddr_t'(rand_bits(15));
        do_fill(a, rand_bits(128));
        do_req(1'b0, a, '0, '0);
        // Same set with a different tag
        do_req(1'b0, {a[14:7] + 8'd1, a[6:0]}, '0, '0);
        report("fill then hit");
    endtask

    task automatic test_write_merge();
        paddr_t a;
        apply_reset();
        a = paddr_t'(rand_bits(15));
        do_fill(a, rand_bits(128));
        do_req(1'b1, a, rand_bits(128), rand_bits(128));
        do_req(1'b0, a, '0, '0);
        report("masked write");
    endtask

    task automatic test_replace();
        index_t s;
        tag_t   t;
        apply_reset();
        s = index_t'(rand_bits(2));
        t = tag_t'(rand_bits(8));
        for (int k = 0; k < 4; k++) begin
            do_fill({t + tag_t'(k), s, 5'b0}, rand_bits(128));
        end
        for (int k = 0; k < 4; k++) begin
            do_req(1'b1, {t + tag_t'(k), s, 5'b0}, rand_bits(128), rand_bits(128));
        end
        do_fill({t + 8'd4, s, 5'b0}, rand_bits(128));
        for (int k = 0; k < 5; k++) begin
            do_req(1'b0, {t + tag_t'(k), s, 5'b0}, '0, '0);
        end
        report("victim replace");
    endtask

    task automatic test_stall();
        paddr_t a;
        int     n;
        apply_reset();
        a         = paddr_t'(rand_bits(15));
        mshr_full = 1'b1;
        drive_req(1'b0, a, '0, '0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!stall && n < TIMEOUT);
        if (!stall) begin
            give_up("stall on a miss with full miss buffer");
        end
        check("stall latency", n, 1);
        repeat (3) begin
            check("stall held", stall, 1'b1);
            check("valid_out in stall", valid_out, 1'b0);
            @(negedge clk);
        end
        @(posedge clk);
        #1 mshr_full = 1'b0;
        @(negedge clk);
        check("valid_out after stall", valid_out, 1'b1);
        check("miss after stall", miss, 1'b1);
        check("ext_addr after stall", ext_addr, {a[14:5], 5'b0});
        @(negedge clk);
        check("single report", valid_out, 1'b0);
        @(posedge clk);
        #1;
        report("stall");
    endtask

    task automatic test_random();
        paddr_t a;
        int     op;
        apply_reset();
        for (int i = 0; i < 100; i++) begin
            a = paddr_t'(rand_bits(15));
            // Eight tags per set keep hits frequent
            a[14:10] = 5'b10100;
            op = int'(rand_bits(2));
            if (op >= 2 && model_way(a) < 0) begin
                do_fill(a, rand_bits(128));
            end else begin
                do_req(op == 1, a, rand_bits(128), rand_bits(128));
            end
        end
        report("random mix");
    endtask

    initial begin
        rst_n      = 1'b0;
        valid      = 1'b0;
        req        = '0;
        fill_valid = 1'b0;
        fill_addr  = '0;
        fill_line  = '0;
        mshr_full  = 1'b0;
        test_reset_miss();
        test_fill_hit();
        test_write_merge();
        test_replace();
        test_stall();
        test_random();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/cache_pkg.sv
rtl/req_decode.sv
rtl/cache_way.sv
rtl/way_resolve.sv
rtl/cache_stage1.sv
sim/tb_cache_stage1.sv
